// File: common/pn_pkg.sv
/*
  shared types and codes for the serial polish-notation calculator
  only whole-expression modes are accepted (prefix 2, postfix 3)
  expressions hold at most TOK_DEPTH tokens, which also sizes the stack
*/
package pn_pkg;

    // ========================================
    // widths and depths
    // ========================================
    localparam int TOK_DEPTH = 12;              // tokens per expression, stack entries

    typedef logic [2:0]         tok_field_t;    // operand value or operator code
    typedef logic signed [31:0] result_t;       // stack entry and final result
    typedef logic [3:0]         tok_idx_t;      // holds 0..TOK_DEPTH
    typedef logic [1:0]         mode_t;
    typedef logic               prefix_t;       // 1 = top of stack is the left operand

    // ========================================
    // codes
    // ========================================
    localparam mode_t MODE_PREFIX  = 2'd2;
    localparam mode_t MODE_POSTFIX = 2'd3;

    // operator codes, anything above OP_ABS_SUM evaluates to zero
    localparam tok_field_t OP_ADD     = 3'd0;
    localparam tok_field_t OP_SUB     = 3'd1;
    localparam tok_field_t OP_MUL     = 3'd2;
    localparam tok_field_t OP_ABS_SUM = 3'd3;

    // ========================================
    // token stream
    // ========================================
    // one replayed token, buffer to evaluator
    typedef struct packed {
        tok_field_t value;
        logic       is_op;
        logic       first;  // stack restarts here
        logic       last;   // result follows one cycle later
    } token_t;

    // buffer sequencer
    typedef enum logic [1:0] {
        IDLE,
        RECEIVE,
        REPLAY,
        WAIT_RESULT
    } buf_state_t;

endpackage

// File: pn_calc/pn_token_buffer.sv
/*
  token store and replay sequencer
  mode is sampled with the first token only; modes 0 and 1 are dropped
  replay of a rejected expression never starts, the FSM goes back to idle
  the first replayed token is issued in the cycle in_valid falls
*/
`timescale 1ns/10ps

module pn_token_buffer (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    input  pn_pkg::mode_t      mode,
    input  logic               operator,
    input  pn_pkg::tok_field_t in,
    input  logic               result_done,
    output logic               tok_valid,
    output pn_pkg::token_t     tok,
    output pn_pkg::prefix_t    prefix
);

    pn_pkg::buf_state_t state;
    pn_pkg::buf_state_t state_d;

    pn_pkg::tok_field_t store_val [pn_pkg::TOK_DEPTH];
    logic               store_op  [pn_pkg::TOK_DEPTH];

    pn_pkg::tok_idx_t   cnt;        // tokens captured
    pn_pkg::tok_idx_t   rd_idx;     // replay pointer
    pn_pkg::tok_idx_t   wr_ptr;
    pn_pkg::mode_t      mode_q;

    logic mode_ok;
    logic capture;
    logic at_last;

    assign mode_ok = (mode_q == pn_pkg::MODE_PREFIX) || (mode_q == pn_pkg::MODE_POSTFIX);
    assign prefix  = pn_pkg::prefix_t'(mode_q == pn_pkg::MODE_PREFIX);
    assign capture = in_valid && (state == pn_pkg::IDLE || state == pn_pkg::RECEIVE);
    assign wr_ptr  = (state == pn_pkg::IDLE) ? '0 : cnt;

    // prefix walks down to entry 0, postfix walks up to the newest entry
    assign at_last = prefix ? (rd_idx == '0)
                            : (rd_idx == pn_pkg::tok_idx_t'(cnt - 1'b1));

    // first replay cycle is RECEIVE with in_valid low
    assign tok_valid = (state == pn_pkg::REPLAY) ||
                       (state == pn_pkg::RECEIVE && !in_valid && mode_ok);

    // ========================================
    // sequencer
    // ========================================
    always_comb begin
        state_d = state;
        case (state)
            pn_pkg::IDLE: begin
                if (in_valid)
                    state_d = pn_pkg::RECEIVE;
            end
            pn_pkg::RECEIVE: begin
                if (!in_valid) begin
                    if (!mode_ok)
                        state_d = pn_pkg::IDLE;         // grouped modes unsupported
                    else if (at_last)
                        state_d = pn_pkg::WAIT_RESULT;  // single token expression
                    else
                        state_d = pn_pkg::REPLAY;
                end
            end
            pn_pkg::REPLAY: begin
                if (at_last)
                    state_d = pn_pkg::WAIT_RESULT;
            end
            pn_pkg::WAIT_RESULT: begin
                if (result_done)
                    state_d = pn_pkg::IDLE;
            end
            default: state_d = pn_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= pn_pkg::IDLE;
        end else begin
            state <= state_d;
        end
    end

    // ========================================
    // capture and pointers
    // ========================================
    always_ff @(posedge clk) begin
        if (capture && wr_ptr < pn_pkg::TOK_DEPTH) begin
            store_val[wr_ptr] <= in;
            store_op[wr_ptr]  <= operator;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt    <= '0;
            rd_idx <= '0;
            mode_q <= '0;
        end else if (state == pn_pkg::IDLE && in_valid) begin
            mode_q <= mode;
            cnt    <= pn_pkg::tok_idx_t'(1);
            rd_idx <= '0;
        end else if (state == pn_pkg::RECEIVE && in_valid) begin
            if (cnt < pn_pkg::TOK_DEPTH) begin
                cnt <= cnt + 1'b1;
                // prefix replays from the newest token
                if (mode_q == pn_pkg::MODE_PREFIX)
                    rd_idx <= cnt;
            end
        end else if (tok_valid && !at_last) begin
            rd_idx <= prefix ? rd_idx - 1'b1 : rd_idx + 1'b1;
        end
    end

    // ========================================
    // token out
    // ========================================
    always_comb begin
        tok.value = store_val[rd_idx];
        tok.is_op = store_op[rd_idx];
        tok.first = (state == pn_pkg::RECEIVE);
        tok.last  = at_last;
    end

endmodule

// File: pn_calc/pn_stack_eval.sv
/*
  operand stack evaluator, one token per cycle, no stall
  an operator with fewer than two entries is skipped
  codes 4..7 push zero; the result is the bottom entry, or zero if empty
  arithmetic wraps at 32 bits
*/
`timescale 1ns/10ps

module pn_stack_eval (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            tok_valid,
    input  pn_pkg::token_t  tok,
    input  pn_pkg::prefix_t prefix,
    output logic            result_done,
    output logic            out_valid,
    output pn_pkg::result_t out
);

    pn_pkg::result_t  stack [pn_pkg::TOK_DEPTH];
    pn_pkg::tok_idx_t sp;               // number of valid entries

    pn_pkg::tok_idx_t base;             // entries seen by this token
    pn_pkg::tok_idx_t nxt_sp;
    logic             can_pop;
    logic             can_push;

    pn_pkg::result_t  top_e;
    pn_pkg::result_t  nxt_e;
    pn_pkg::result_t  lhs;
    pn_pkg::result_t  rhs;
    pn_pkg::result_t  sum;
    pn_pkg::result_t  op_res;
    pn_pkg::result_t  operand;
    pn_pkg::result_t  new_bottom;       // stack[0] after this token

    // ========================================
    // operand fetch and arithmetic
    // ========================================
    always_comb begin
        base     = tok.first ? '0 : sp;     // new expression starts empty
        can_pop  = tok.is_op && (base >= 2);
        can_push = !tok.is_op && (base < pn_pkg::TOK_DEPTH);
        operand  = pn_pkg::result_t'(tok.value);    // zero extended

        top_e = '0;
        nxt_e = '0;
        if (base >= 2) begin
            top_e = stack[base - 1'b1];
            nxt_e = stack[base - 2'd2];
        end

        // prefix: popped first is the left side
        lhs = prefix ? top_e : nxt_e;
        rhs = prefix ? nxt_e : top_e;
        sum = lhs + rhs;

        case (tok.value)
            pn_pkg::OP_ADD:     op_res = sum;
            pn_pkg::OP_SUB:     op_res = lhs - rhs;
            pn_pkg::OP_MUL:     op_res = lhs * rhs;
            pn_pkg::OP_ABS_SUM: op_res = (sum < 0) ? -sum : sum;
            default:            op_res = '0;
        endcase
    end

    // ========================================
    // next pointer and bottom entry
    // ========================================
    always_comb begin
        nxt_sp     = base;
        new_bottom = (base == '0) ? '0 : stack[0];
        if (can_push) begin
            nxt_sp = base + 1'b1;
            if (base == '0)
                new_bottom = operand;
        end else if (can_pop) begin
            nxt_sp = base - 1'b1;
            if (base == pn_pkg::tok_idx_t'(2))
                new_bottom = op_res;    // the pair was the whole stack
        end
    end

    always_ff @(posedge clk) begin
        if (tok_valid) begin
            if (can_push)
                stack[base] <= operand;
            else if (can_pop)
                stack[base - 2'd2] <= op_res;   // two out, one in
        end
    end

    // ========================================
    // pointer and result register
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sp        <= '0;
            out_valid <= 1'b0;
            out       <= '0;
        end else begin
            if (tok_valid)
                sp <= nxt_sp;
            out_valid <= tok_valid && tok.last;
            out       <= (tok_valid && tok.last) ? new_bottom : '0;  // zero when idle
        end
    end

    assign result_done = out_valid;   // same cycle as the result

endmodule

// File: hdl/pn_top.sv
/*
  polish-notation calculator top level
  valid-only protocol, no back-pressure: do not drive in_valid while busy
  a result appears N+1 cycles after the last of N input tokens
*/
`timescale 1ns/10ps

module pn_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    input  pn_pkg::mode_t      mode,
    input  logic               operator,
    input  pn_pkg::tok_field_t in,
    output logic               out_valid,
    output pn_pkg::result_t    out
);

    logic            tok_valid;
    pn_pkg::token_t  tok;
    pn_pkg::prefix_t prefix;
    logic            result_done;   // releases the buffer back to idle

    // capture and reorder
    pn_token_buffer i_token_buffer (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .mode        (mode),
        .operator    (operator),
        .in          (in),
        .result_done (result_done),
        .tok_valid   (tok_valid),
        .tok         (tok),
        .prefix      (prefix)
    );

    // one token per cycle on the operand stack
    pn_stack_eval i_stack_eval (
        .clk         (clk),
        .rst_n       (rst_n),
        .tok_valid   (tok_valid),
        .tok         (tok),
        .prefix      (prefix),
        .result_done (result_done),
        .out_valid   (out_valid),
        .out         (out)
    );

endmodule

// File: dv/pn_asserts.sv
/*
  timing checks for the calculator, bound to pn_top
  assumes in_valid is never raised while an expression is in flight
  fail_cnt counts failed checks so the testbench can pick them up
*/
`timescale 1ns/10ps

module pn_asserts (
    input logic               clk,
    input logic               rst_n,
    input logic               in_valid,
    input pn_pkg::mode_t      mode,
    input pn_pkg::buf_state_t state,
    input logic               out_valid,
    input pn_pkg::result_t    out
);

    int            fail_cnt = 0;
    logic          in_valid_q;
    logic          pending;         // accepted expression waiting for its result
    logic [4:0]    n_tok;           // tokens in the current expression
    logic [4:0]    since;           // cycles after the in_valid fall
    pn_pkg::mode_t mode_first;
    logic          mode_ok;
    logic          in_fall;

    assign mode_ok = (mode_first == pn_pkg::MODE_PREFIX) || (mode_first == pn_pkg::MODE_POSTFIX);
    assign in_fall = in_valid_q && !in_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_valid_q <= 1'b0;
            pending    <= 1'b0;
            n_tok      <= '0;
            since      <= '0;
            mode_first <= '0;
        end else begin
            in_valid_q <= in_valid;
            if (in_valid && state == pn_pkg::IDLE) begin
                n_tok      <= 5'd1;
                mode_first <= mode;     // mode only counts on the first token
            end else if (in_valid) begin
                n_tok <= n_tok + 1'b1;
            end
            if (in_fall && mode_ok) begin
                pending <= 1'b1;
                since   <= 5'd1;
            end else if (out_valid) begin
                pending <= 1'b0;
                since   <= '0;
            end else if (pending) begin
                since <= since + 1'b1;
            end
        end
    end

    // ========================================
    // properties
    // ========================================
    a_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |=> !out_valid)
        else begin fail_cnt++; $error("out_valid lasted more than one cycle"); end

    a_out_zero: assert property (@(posedge clk) disable iff (!rst_n)
        !out_valid |-> out == '0)
        else begin fail_cnt++; $error("out is not zero while out_valid is low"); end

    a_latency_hit: assert property (@(posedge clk) disable iff (!rst_n)
        pending && since == n_tok |-> out_valid)
        else begin fail_cnt++; $error("result missing N+1 cycles after the last token"); end

    a_latency_only: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> pending && since == n_tok)
        else begin fail_cnt++; $error("out_valid at an unexpected cycle"); end

    // rejected mode goes straight back to idle
    a_reject_idle: assert property (@(posedge clk) disable iff (!rst_n)
        in_fall && !mode_ok |=> state == pn_pkg::IDLE)
        else begin fail_cnt++; $error("buffer did not return to idle on a rejected mode"); end

    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |-> !out_valid)
        else begin fail_cnt++; $error("out_valid high during reset"); end

endmodule

// File: dv/pn_tb.sv
/*
  testbench for the polish-notation calculator
  inputs change on the rising edge, outputs are sampled on the falling edge
  random expressions come from a fixed-seed LFSR, at most 12 tokens each
*/
`timescale 1ns/10ps

module pn_tb;

    localparam int RESULT_TIMEOUT = 40;     // cycles
    localparam int REJECT_WINDOW  = 30;

    logic               clk;
    logic               rst_n;
    logic               in_valid;
    pn_pkg::mode_t      mode;
    logic               operator;
    pn_pkg::tok_field_t in;
    logic               out_valid;
    pn_pkg::result_t    out;

    logic [31:0]        lfsr = 32'hf19cdc38;
    pn_pkg::tok_field_t ex_val [$];         // expression in written order
    logic               ex_op  [$];

    pn_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .mode      (mode),
        .operator  (operator),
        .in        (in),
        .out_valid (out_valid),
        .out       (out)
    );

    bind pn_top pn_asserts i_asserts (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .mode      (mode),
        .state     (i_token_buffer.state),
        .out_valid (out_valid),
        .out       (out)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ========================================
    // helpers
    // ========================================
    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_asserts();
        if (i_dut.i_asserts.fail_cnt != 0)
            fail_now("a timing assertion on the DUT outputs failed");
    endtask

    task automatic check_value(input string name, input pn_pkg::result_t exp);
        assert (out === exp)
        else fail_now($sformatf("MISMATCH %s expected %0d actual %0d", name, exp, out));
    endtask

    // digits are operands; + - * | are codes 0..3, # is code 5, ? is code 7
    task automatic load_expr(input string s);
        byte c;
        ex_val.delete();
        ex_op.delete();
        for (int i = 0; i < s.len(); i++) begin
            c = s[i];
            ex_op.push_back(1'b1);
            case (c)
                "+":     ex_val.push_back(3'd0);
                "-":     ex_val.push_back(3'd1);
                "*":     ex_val.push_back(3'd2);
                "|":     ex_val.push_back(3'd3);
                "#":     ex_val.push_back(3'd5);
                "?":     ex_val.push_back(3'd7);
                default: begin
                    ex_op[ex_op.size() - 1] = 1'b0;
                    ex_val.push_back(pn_pkg::tok_field_t'(c - "0"));
                end
            endcase
        end
    endtask

    // well-formed postfix, n_ops operators and n_ops+1 operands
    task automatic build_postfix(input int n_ops);
        int   depth;
        int   opnd_left;
        int   ops_left;
        logic take_op;
        ex_val.delete();
        ex_op.delete();
        depth     = 0;
        opnd_left = n_ops + 1;
        ops_left  = n_ops;
        while (opnd_left + ops_left > 0) begin
            take_op = (depth >= 2) && (ops_left > 0) &&
                      (opnd_left == 0 || lfsr_bits(1) == 32'd1);
            if (take_op) begin
                ex_val.push_back(pn_pkg::tok_field_t'(lfsr_bits(2)));  // codes 0..3
                ex_op.push_back(1'b1);
                ops_left--;
                depth--;
            end else begin
                ex_val.push_back(pn_pkg::tok_field_t'(lfsr_bits(3)));
                ex_op.push_back(1'b0);
                opnd_left--;
                depth++;
            end
        end
    endtask

    // reversed postfix reads as a well-formed prefix
    task automatic reverse_expr();
        pn_pkg::tok_field_t v [$];
        logic               o [$];
        v = ex_val;
        o = ex_op;
        ex_val.delete();
        ex_op.delete();
        for (int i = v.size() - 1; i >= 0; i--) begin
            ex_val.push_back(v[i]);
            ex_op.push_back(o[i]);
        end
    endtask

    // reference stack model
    function automatic pn_pkg::result_t model_eval(input logic is_prefix);
        pn_pkg::result_t stk [$];
        pn_pkg::result_t top_v;
        pn_pkg::result_t below_v;
        pn_pkg::result_t l;
        pn_pkg::result_t r;
        pn_pkg::result_t res;
        int              k;
        for (int i = 0; i < ex_val.size(); i++) begin
            k = is_prefix ? ex_val.size() - 1 - i : i;
            if (!ex_op[k]) begin
                stk.push_back(pn_pkg::result_t'({29'd0, ex_val[k]}));
            end else if (stk.size() >= 2) begin
                top_v   = stk.pop_back();
                below_v = stk.pop_back();
                l = is_prefix ? top_v : below_v;
                r = is_prefix ? below_v : top_v;
                case (ex_val[k])
                    3'd0:    res = l + r;
                    3'd1:    res = l - r;
                    3'd2:    res = l * r;
                    3'd3: begin
                        res = l + r;
                        if (res < 0)
                            res = -res;
                    end
                    default: res = '0;
                endcase
                stk.push_back(res);
            end
        end
        return (stk.size() == 0) ? pn_pkg::result_t'(0) : stk[0];
    endfunction

    task automatic send_expr(input pn_pkg::mode_t m);
        for (int i = 0; i < ex_val.size(); i++) begin
            @(posedge clk);
            in_valid <= 1'b1;
            mode     <= (i == 0) ? m : pn_pkg::mode_t'(lfsr_bits(2));  // ignored after first
            operator <= ex_op[i];
            in       <= ex_val[i];
        end
        @(posedge clk);
        in_valid <= 1'b0;
        operator <= 1'b0;
        in       <= '0;
    endtask

    task automatic wait_result(input string name);
        int cyc;
        cyc = 0;
        @(negedge clk);
        while (!out_valid) begin
            check_asserts();
            cyc++;
            if (cyc > RESULT_TIMEOUT)
                fail_now($sformatf("timeout waiting for the result of %s", name));
            @(negedge clk);
        end
        check_asserts();
    endtask

    task automatic run_expr(input string name, input pn_pkg::mode_t m,
                            input pn_pkg::result_t exp);
        send_expr(m);
        wait_result(name);
        check_value(name, exp);
    endtask

    task automatic expect_no_result(input string name);
        for (int cyc = 0; cyc < REJECT_WINDOW; cyc++) begin
            @(negedge clk);
            check_asserts();
            if (out_valid)
                fail_now($sformatf("%s produced a result although its mode is rejected", name));
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        for (int cyc = 0; cyc < 5; cyc++) begin
            @(negedge clk);
            if (out_valid)
                fail_now("out_valid went high while reset was asserted");
        end
        @(posedge clk);
        rst_n <= 1'b1;
    endtask

    // ========================================
    // test sequence
    // ========================================
    initial begin
        pn_pkg::result_t exp;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        mode      = '0;
        operator  = 1'b0;
        in        = '0;
        apply_reset();

        // operand order and malformed input
        load_expr("27-");
        run_expr("sub_postfix", pn_pkg::MODE_POSTFIX, -5);
        load_expr("-27");
        run_expr("sub_prefix", pn_pkg::MODE_PREFIX, -5);
        load_expr("*-723");
        run_expr("mul_sub_prefix", pn_pkg::MODE_PREFIX, 15);
        load_expr("+46*");
        run_expr("skip_short_op", pn_pkg::MODE_POSTFIX, 24);
        load_expr("35#");
        run_expr("unknown_code", pn_pkg::MODE_POSTFIX, 0);
        load_expr("#41");
        run_expr("unknown_prefix", pn_pkg::MODE_PREFIX, 0);
        load_expr("5+");
        run_expr("skip_prefix", pn_pkg::MODE_PREFIX, 5);
        load_expr("7");
        run_expr("single_postfix", pn_pkg::MODE_POSTFIX, 7);
        load_expr("6");
        run_expr("single_prefix", pn_pkg::MODE_PREFIX, 6);
        load_expr("*");
        run_expr("lone_operator", pn_pkg::MODE_POSTFIX, 0);
        load_expr("16-0|");
        run_expr("abs_sum", pn_pkg::MODE_POSTFIX, 5);
        load_expr("123456+++++?");
        run_expr("max_length", pn_pkg::MODE_POSTFIX, 21);

        for (int i = 0; i < 20; i++) begin
            build_postfix(1 + int'(lfsr_bits(3)) % 5);
            exp = model_eval(1'b0);
            run_expr($sformatf("postfix_%0d", i), pn_pkg::MODE_POSTFIX, exp);
        end
        for (int i = 0; i < 20; i++) begin
            build_postfix(1 + int'(lfsr_bits(3)) % 5);
            reverse_expr();
            exp = model_eval(1'b1);
            run_expr($sformatf("prefix_%0d", i), pn_pkg::MODE_PREFIX, exp);
        end

        // grouped modes are dropped
        load_expr("34+");
        send_expr(2'd0);
        expect_no_result("reject_mode0");
        load_expr("12*");
        send_expr(2'd1);
        expect_no_result("reject_mode1");
        load_expr("34+");
        run_expr("after_reject", pn_pkg::MODE_POSTFIX, 7);

        // reset during replay
        build_postfix(5);
        send_expr(pn_pkg::MODE_POSTFIX);
        repeat (3) @(posedge clk);
        apply_reset();
        load_expr("75-");
        run_expr("after_reset", pn_pkg::MODE_POSTFIX, 2);
        load_expr("-75");
        run_expr("prefix_after_reset", pn_pkg::MODE_PREFIX, 2);

        repeat (2) @(negedge clk);
        if (i_dut.i_asserts.fail_cnt == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            fail_now("a timing assertion failed after the last result");
        end
    end

endmodule

// File: tb.f
common/pn_pkg.sv
pn_calc/pn_token_buffer.sv
pn_calc/pn_stack_eval.sv
hdl/pn_top.sv
dv/pn_asserts.sv
dv/pn_tb.sv
